/* evrEventPkg.sv */
package evrEventPkg;

    //////////////////////////////////////////////////
    // event stream types
    //////////////////////////////////////////////////

    // one byte per recovered link cycle
    typedef logic [7:0] eventCode_t;

    // code 0 carries no event
    localparam eventCode_t NullCode = 8'h00;

    // mapping RAM word
    typedef logic [15:0] mapWord_t;

    // bit 15 raises the event interrupt
    localparam int IrqBit = 15;

    // fire bits 0..7 of a mapping word
    localparam int MaxChannels = 8;

    //////////////////////////////////////////////////
    // trigger channel types
    //////////////////////////////////////////////////

    // delay or width in link cycles
    typedef logic [31:0] pulseCount_t;

    typedef struct packed {
        pulseCount_t delay;
        pulseCount_t width;
        logic        polarity;
    } channelCfg_t;

    // pulse generator states
    typedef enum logic [1:0] {
        IDLE,
        DELAY,
        ACTIVE
    } trigState_t;

endpackage

/* evrBusPkg.sv */
package evrBusPkg;

    //////////////////////////////////////////////////
    // APB types
    //////////////////////////////////////////////////

    typedef logic [11:0] apbAddr_t;
    typedef logic [31:0] apbData_t;

    // register or RAM index from the address
    typedef logic [7:0] regIndex_t;

    // address layout
    // bit 10 picks the bank, 9..2 the index, 1..0 always zero
    localparam int BankBit  = 10;
    localparam int IndexMsb = 9;
    localparam int IndexLsb = 2;

    typedef struct packed {
        logic     psel;
        logic     penable;
        logic     pwrite;
        apbAddr_t paddr;
        apbData_t pwdata;
    } apbReq_t;

    typedef struct packed {
        apbData_t prdata;
        logic     pready;
        logic     pslverr;
    } apbRsp_t;

    //////////////////////////////////////////////////
    // mapping RAM port request and response
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                    request;
        logic                    write;
        evrEventPkg::eventCode_t index;
        evrEventPkg::mapWord_t   wdata;
    } mapReq_t;

    // rdata valid the cycle after a granted read
    typedef struct packed {
        logic                  grant;
        evrEventPkg::mapWord_t rdata;
    } mapRsp_t;

    // register bank indices
    // channel c delay at 2c, width at 2c+1
    localparam regIndex_t RegPolarity = 8'd16;
    localparam regIndex_t RegStatus   = 8'd17;
    localparam regIndex_t RegId       = 8'd18;

    localparam apbData_t EvrId = 32'hE7E0_0104;

endpackage

/* evrApbRegs.sv */
`timescale 1ns/1ps

module evrApbRegs #(
    parameter int NumChannels = 4
) (
    input  logic                     mgt_rec_clk,
    input  logic                     bus_reset_n,
    input  evrBusPkg::apbReq_t       apbReq,
    output evrBusPkg::apbRsp_t       apbRsp,
    output evrBusPkg::mapReq_t       mapReq,
    input  evrBusPkg::mapRsp_t       mapRsp,
    input  logic                     eventIrq,
    output evrEventPkg::channelCfg_t channelCfg [NumChannels],
    output logic [NumChannels-1:0]   cfgWrite,
    output logic                     intrEvent
);

    // delay and width registers occupy 0 .. 2*NumChannels-1
    localparam int ChanRegs = 2 * NumChannels;

    // register storage
    evrEventPkg::pulseCount_t delayReg [NumChannels];
    evrEventPkg::pulseCount_t widthReg [NumChannels];
    // one polarity bit per possible channel
    logic [evrEventPkg::MaxChannels-1:0] polarityReg;
    logic eventFlag;

    // map read waits one cycle for the RAM output register
    logic readPending;

    // decoded transfer
    logic                 access;
    logic                 mapBank;
    evrBusPkg::regIndex_t index;
    logic                 regAccess;
    logic                 mapAccess;
    logic                 chanHit;
    logic                 regValid;
    logic                 regWritable;
    logic                 regWrite;
    evrBusPkg::apbData_t  regRdata;

    //////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////

    assign access  = apbReq.psel && apbReq.penable;
    assign mapBank = apbReq.paddr[evrBusPkg::BankBit];
    assign index   = apbReq.paddr[evrBusPkg::IndexMsb:evrBusPkg::IndexLsb];

    assign regAccess = access && !mapBank;
    assign mapAccess = access && mapBank;

    assign chanHit = (index < ChanRegs);
    // ID is read only
    assign regWritable = chanHit || (index == evrBusPkg::RegPolarity) ||
                         (index == evrBusPkg::RegStatus);
    assign regValid    = regWritable || (index == evrBusPkg::RegId);
    assign regWrite    = regAccess && apbReq.pwrite && regWritable;

    //////////////////////////////////////////////////
    // register bank
    //////////////////////////////////////////////////

    always_ff @(posedge mgt_rec_clk) begin
        if (!bus_reset_n) begin
            for (int c = 0; c < NumChannels; c++) begin
                delayReg[c] <= '0;
                widthReg[c] <= '0;
            end
            polarityReg <= '0;
        end else if (regWrite) begin
            for (int c = 0; c < NumChannels; c++) begin
                if (index == 2 * c) begin
                    delayReg[c] <= apbReq.pwdata;
                end
                if (index == 2 * c + 1) begin
                    widthReg[c] <= apbReq.pwdata;
                end
            end
            if (index == evrBusPkg::RegPolarity) begin
                polarityReg <= apbReq.pwdata[evrEventPkg::MaxChannels-1:0];
            end
        end
    end

    // sticky event flag
    // a new event wins over a clear
    always_ff @(posedge mgt_rec_clk) begin
        if (!bus_reset_n) begin
            eventFlag <= 1'b0;
        end else if (eventIrq) begin
            eventFlag <= 1'b1;
        end else if (regWrite && index == evrBusPkg::RegStatus && apbReq.pwdata[0]) begin
            eventFlag <= 1'b0;
        end
    end

    assign intrEvent = eventFlag;

    // channel restarts on its own delay/width write or any polarity write
    always_comb begin
        for (int c = 0; c < NumChannels; c++) begin
            cfgWrite[c] = regWrite &&
                          ((index == evrBusPkg::RegPolarity) || ((index >> 1) == c));
            channelCfg[c].delay    = delayReg[c];
            channelCfg[c].width    = widthReg[c];
            channelCfg[c].polarity = polarityReg[c];
        end
    end

    // read mux
    always_comb begin
        regRdata = '0;
        for (int c = 0; c < NumChannels; c++) begin
            if (index == 2 * c) begin
                regRdata = delayReg[c];
            end
            if (index == 2 * c + 1) begin
                regRdata = widthReg[c];
            end
        end
        if (index == evrBusPkg::RegPolarity) begin
            regRdata = 32'(polarityReg);
        end
        if (index == evrBusPkg::RegStatus) begin
            regRdata = 32'(eventFlag);
        end
        if (index == evrBusPkg::RegId) begin
            regRdata = evrBusPkg::EvrId;
        end
    end

    //////////////////////////////////////////////////
    // map bank forwarding
    //////////////////////////////////////////////////

    // request held through access until granted
    assign mapReq.request = mapAccess && !readPending;
    assign mapReq.write   = apbReq.pwrite;
    assign mapReq.index   = index;
    assign mapReq.wdata   = apbReq.pwdata[15:0];

    always_ff @(posedge mgt_rec_clk) begin
        if (!bus_reset_n) begin
            readPending <= 1'b0;
        end else begin
            readPending <= mapRsp.grant && !apbReq.pwrite;
        end
    end

    // response
    // register bank has no wait states
    // map writes end on grant
    always_comb begin
        apbRsp.pready  = regAccess || (mapRsp.grant && apbReq.pwrite) || readPending;
        apbRsp.pslverr = regAccess && (apbReq.pwrite ? !regWritable : !regValid);
        apbRsp.prdata  = readPending ? {16'b0, mapRsp.rdata} : regRdata;
    end

endmodule

/* mapRamArbiter.sv */
`timescale 1ns/1ps

module mapRamArbiter (
    input  logic                    mgt_rec_clk,
    input  logic                    bus_reset_n,
    input  evrEventPkg::eventCode_t eventByte,
    input  logic                    eventByteIsK,
    input  evrBusPkg::mapReq_t      mapReq,
    output evrBusPkg::mapRsp_t      mapRsp,
    output evrEventPkg::mapWord_t   hitWord
);

    // one word per event code
    localparam int Depth = 2 ** $bits(evrEventPkg::eventCode_t);

    evrEventPkg::mapWord_t   mapRam [Depth];
    // shared RAM output register
    evrEventPkg::mapWord_t   ramQ;
    evrEventPkg::eventCode_t ramAddr;

    logic eventIdle;
    logic grant;
    logic lookupValid;

    //////////////////////////////////////////////////
    // fixed priority arbiter
    //////////////////////////////////////////////////

    // null and K cycles leave the port free
    assign eventIdle = eventByteIsK || (eventByte == evrEventPkg::NullCode);

    // event lookup always wins
    // bus only gets the port on idle cycles
    assign grant = mapReq.request && eventIdle;

    // port address mux
    assign ramAddr = eventIdle ? mapReq.index : eventByte;

    //////////////////////////////////////////////////
    // single port RAM
    //////////////////////////////////////////////////

    // read first
    // a bus write lands in its granted cycle
    always_ff @(posedge mgt_rec_clk) begin
        if (grant && mapReq.write) begin
            mapRam[ramAddr] <= mapReq.wdata;
        end
        ramQ <= mapRam[ramAddr];
    end

    // marks ramQ as an event lookup
    always_ff @(posedge mgt_rec_clk) begin
        if (!bus_reset_n) begin
            lookupValid <= 1'b0;
        end else begin
            lookupValid <= !eventIdle;
        end
    end

    // hit word is zero after null, K or bus cycles
    assign hitWord = lookupValid ? ramQ : '0;

    // bus read data appears the cycle after grant
    assign mapRsp.grant = grant;
    assign mapRsp.rdata = ramQ;

endmodule

/* triggerChannel.sv */
`timescale 1ns/1ps

module triggerChannel (
    input  logic                     mgt_rec_clk,
    input  logic                     bus_reset_n,
    input  evrEventPkg::channelCfg_t cfg,
    input  logic                     cfgWrite,
    input  logic                     fire,
    output logic                     trigger
);

    evrEventPkg::trigState_t  state;
    evrEventPkg::trigState_t  nextState;
    // shared down counter for delay and width
    evrEventPkg::pulseCount_t count;
    evrEventPkg::pulseCount_t nextCount;
    logic                     countDone;

    assign countDone = (count == '0);

    //////////////////////////////////////////////////
    // pulse FSM
    //////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        nextCount = count;
        case (state)
            evrEventPkg::IDLE: begin
                // zero width means no pulse at all
                if (fire && cfg.width != '0) begin
                    if (cfg.delay == '0) begin
                        nextState = evrEventPkg::ACTIVE;
                        nextCount = cfg.width - 1'b1;
                    end else begin
                        nextState = evrEventPkg::DELAY;
                        nextCount = cfg.delay - 1'b1;
                    end
                end
            end
            evrEventPkg::DELAY: begin
                // fire ignored until back in idle
                if (countDone) begin
                    nextState = evrEventPkg::ACTIVE;
                    nextCount = cfg.width - 1'b1;
                end else begin
                    nextCount = count - 1'b1;
                end
            end
            evrEventPkg::ACTIVE: begin
                if (countDone) begin
                    nextState = evrEventPkg::IDLE;
                end else begin
                    nextCount = count - 1'b1;
                end
            end
            default: begin
                nextState = evrEventPkg::IDLE;
            end
        endcase
    end

    // config write drops a pending or running pulse
    always_ff @(posedge mgt_rec_clk) begin
        if (!bus_reset_n || cfgWrite) begin
            state <= evrEventPkg::IDLE;
        end else begin
            state <= nextState;
        end
    end

    // loaded at the start of each delay or width
    always_ff @(posedge mgt_rec_clk) begin
        count <= nextCount;
    end

    // active level follows polarity
    assign trigger = (state == evrEventPkg::ACTIVE) ^ cfg.polarity;

endmodule

/* eventReceiverTop.sv */
`timescale 1ns/1ps

module eventReceiverTop #(
    parameter int NumChannels = 4
) (
    input  logic                    mgt_rec_clk,
    input  logic                    bus_reset_n,
    input  evrBusPkg::apbReq_t      apbReq,
    output evrBusPkg::apbRsp_t      apbRsp,
    input  evrEventPkg::eventCode_t eventByte,
    input  logic                    eventByteIsK,
    output logic [NumChannels-1:0]  triggers,
    output logic                    intrEvent
);

    // register bank to arbiter
    evrBusPkg::mapReq_t mapReq;
    evrBusPkg::mapRsp_t mapRsp;

    // looked-up mapping word one cycle after the event byte
    evrEventPkg::mapWord_t hitWord;

    // register bank to channels
    evrEventPkg::channelCfg_t channelCfg [NumChannels];
    logic [NumChannels-1:0]   cfgWrite;

    //////////////////////////////////////////////////
    // bus side
    //////////////////////////////////////////////////

    evrApbRegs #(
        .NumChannels(NumChannels)
    ) evrApbRegs_i (
        .mgt_rec_clk(mgt_rec_clk),
        .bus_reset_n(bus_reset_n),
        .apbReq     (apbReq),
        .apbRsp     (apbRsp),
        .mapReq     (mapReq),
        .mapRsp     (mapRsp),
        .eventIrq   (hitWord[evrEventPkg::IrqBit]),
        .channelCfg (channelCfg),
        .cfgWrite   (cfgWrite),
        .intrEvent  (intrEvent)
    );

    mapRamArbiter mapRamArbiter_i (
        .mgt_rec_clk (mgt_rec_clk),
        .bus_reset_n (bus_reset_n),
        .eventByte   (eventByte),
        .eventByteIsK(eventByteIsK),
        .mapReq      (mapReq),
        .mapRsp      (mapRsp),
        .hitWord     (hitWord)
    );

    //////////////////////////////////////////////////
    // trigger outputs
    //////////////////////////////////////////////////

    // channel c fires on hit bit c
    for (genvar c = 0; c < NumChannels; c++) begin : gChannel
        triggerChannel triggerChannel_i (
            .mgt_rec_clk(mgt_rec_clk),
            .bus_reset_n(bus_reset_n),
            .cfg        (channelCfg[c]),
            .cfgWrite   (cfgWrite[c]),
            .fire       (hitWord[c]),
            .trigger    (triggers[c])
        );
    end

endmodule

/* evrClockGen.sv */
`timescale 1ns/1ps

module evrClockGen #(
    parameter int Period      = 10,
    parameter int ResetCycles = 4
) (
    output logic mgt_rec_clk,
    output logic bus_reset_n
);

    // free running link clock
    initial begin
        mgt_rec_clk = 1'b0;
        forever #(Period / 2) mgt_rec_clk = ~mgt_rec_clk;
    end

    // reset released just after an edge
    initial begin
        bus_reset_n = 1'b0;
        repeat (ResetCycles) @(posedge mgt_rec_clk);
        #1;
        bus_reset_n = 1'b1;
    end

endmodule

/* evrApb_asserts.sv */
`timescale 1ns/1ps

module evrApbAsserts (
    input logic               mgt_rec_clk,
    input logic               bus_reset_n,
    input evrBusPkg::apbReq_t apbReq,
    input evrBusPkg::apbRsp_t apbRsp,
    input evrBusPkg::mapRsp_t mapRsp
);

    // failure tally
    int failCount = 0;

    logic accessPhase;

    assign accessPhase = apbReq.psel && apbReq.penable;

    //////////////////////////////////////////////////
    // APB handshake
    //////////////////////////////////////////////////

    // pready only ever in an access cycle
    readyInAccess: assert property (@(posedge mgt_rec_clk) disable iff (!bus_reset_n)
        apbRsp.pready |-> accessPhase)
    else begin
        failCount++;
        $error("pready high outside an APB access phase");
    end

    // one grant per map access
    // write ends on grant and read one cycle later
    grantToReady: assert property (@(posedge mgt_rec_clk) disable iff (!bus_reset_n)
        mapRsp.grant |=> !mapRsp.grant && (apbRsp.pready || $past(apbRsp.pready)))
    else begin
        failCount++;
        $error("granted map access did not end with pready within one cycle");
    end

    // master holds the request through wait states
    requestStable: assert property (@(posedge mgt_rec_clk) disable iff (!bus_reset_n)
        (accessPhase && !apbRsp.pready) |=> $stable(apbReq))
    else begin
        failCount++;
        $error("APB request changed while pready was low");
    end

endmodule

bind evrApbRegs evrApbAsserts evrApbAsserts_i (
    .mgt_rec_clk(mgt_rec_clk),
    .bus_reset_n(bus_reset_n),
    .apbReq     (apbReq),
    .apbRsp     (apbRsp),
    .mapRsp     (mapRsp)
);

/* eventReceiverTb.sv */
`timescale 1ns/1ps

module eventReceiverTb;

    localparam int NumChannels = 4;
    localparam int ClkPeriod   = 10;
    localparam int RandomSeed  = 28416;
    localparam int DriveDelay  = 1;
    // idle cycles between pulses exceed any delay plus width
    localparam int Gap         = 40;
    localparam int NumPulses   = 6;
    localparam int BusyCycles  = 12;
    localparam int MaxWait     = 100;
    // registers, RAM, pulses, arbitration, interrupt, reconfiguration
    localparam int TestCycles  = 100 + 60 + 40 + NumPulses * (Gap + 2) + 3 * BusyCycles + 40 + 90;

    localparam evrEventPkg::eventCode_t BusyCode   = 8'h7E;
    localparam evrEventPkg::eventCode_t IrqCode    = 8'h7D;
    localparam evrEventPkg::eventCode_t ReconfCode = 8'h7C;
    // K28.5 comma
    localparam evrEventPkg::eventCode_t CommaK     = 8'hBC;

    logic                    mgt_rec_clk;
    logic                    bus_reset_n;
    evrBusPkg::apbReq_t      apbReq;
    evrBusPkg::apbRsp_t      apbRsp;
    evrEventPkg::eventCode_t eventByte;
    logic                    eventByteIsK;
    logic [NumChannels-1:0]  triggers;
    logic                    intrEvent;

    // expected state of the DUT
    evrEventPkg::channelCfg_t shadowCfg [NumChannels];
    int                       fireCycle [NumChannels];
    evrEventPkg::mapWord_t    ramShadow [256];

    int cycleCount     = 0;
    int valueErrors    = 0;
    int protocolErrors = 0;
    int assertErrors   = 0;

    evrClockGen #(
        .Period     (ClkPeriod),
        .ResetCycles(4)
    ) evrClockGen_i (
        .mgt_rec_clk(mgt_rec_clk),
        .bus_reset_n(bus_reset_n)
    );

    eventReceiverTop #(
        .NumChannels(NumChannels)
    ) eventReceiverTop_i (
        .mgt_rec_clk (mgt_rec_clk),
        .bus_reset_n (bus_reset_n),
        .apbReq      (apbReq),
        .apbRsp      (apbRsp),
        .eventByte   (eventByte),
        .eventByteIsK(eventByteIsK),
        .triggers    (triggers),
        .intrEvent   (intrEvent)
    );

    // edge count
    // value after edge n is n
    always @(posedge mgt_rec_clk) begin
        cycleCount <= cycleCount + 1;
    end

    //////////////////////////////////////////////////
    // reference model and compare
    //////////////////////////////////////////////////

    // event driven after edge k
    // active from edge k+2+delay for width cycles
    function automatic logic expectedTrigger(evrEventPkg::channelCfg_t cfg, int fired, int now);
        int start;
        start = fired + 2 + int'(cfg.delay);
        if (fired < 0 || cfg.width == '0) begin
            return cfg.polarity;
        end
        return ((now >= start) && (now < start + int'(cfg.width))) ^ cfg.polarity;
    endfunction

    // every trigger, every cycle, mid period
    always @(negedge mgt_rec_clk) begin
        if (bus_reset_n) begin
            for (int c = 0; c < NumChannels; c++) begin
                assert (triggers[c] === expectedTrigger(shadowCfg[c], fireCycle[c], cycleCount))
                else begin
                    valueErrors++;
                    $display("FAIL %0t: trigger %0d is %b at cycle %0d", $time, c,
                             triggers[c], cycleCount);
                end
            end
        end
    end

    function automatic evrBusPkg::apbAddr_t regAddress(evrBusPkg::regIndex_t idx);
        return {2'b00, idx, 2'b00};
    endfunction

    function automatic evrBusPkg::apbAddr_t ramAddress(evrBusPkg::regIndex_t idx);
        return {2'b01, idx, 2'b00};
    endfunction

    task automatic compareWord(input string what, input evrBusPkg::apbData_t got,
                               input evrBusPkg::apbData_t exp);
        assert (got === exp)
        else begin
            valueErrors++;
            $display("FAIL %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // APB master
    //////////////////////////////////////////////////

    task automatic busTransfer(input logic write, input evrBusPkg::apbAddr_t addr,
                               input evrBusPkg::apbData_t wdata, input logic expErr,
                               output evrBusPkg::apbData_t rdata);
        int waited;
        waited = 0;
        // setup
        @(posedge mgt_rec_clk);
        #DriveDelay;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = write;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        // access held until pready
        @(posedge mgt_rec_clk);
        #DriveDelay;
        apbReq.penable = 1'b1;
        @(negedge mgt_rec_clk);
        while (!apbRsp.pready && waited < MaxWait) begin
            waited++;
            @(negedge mgt_rec_clk);
        end
        if (!apbRsp.pready) begin
            protocolErrors++;
            $display("APB transfer to 0x%03h got no pready in %0d cycles", addr, MaxWait);
        end
        rdata = apbRsp.prdata;
        assert (apbRsp.pslverr === expErr)
        else begin
            valueErrors++;
            $display("FAIL %0t: pslverr %b at 0x%03h, expected %b", $time, apbRsp.pslverr,
                     addr, expErr);
        end
        @(posedge mgt_rec_clk);
        #DriveDelay;
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    task automatic storeWord(input evrBusPkg::apbAddr_t addr, input evrBusPkg::apbData_t data,
                             input logic expErr);
        evrBusPkg::apbData_t unused;
        busTransfer(1'b1, addr, data, expErr, unused);
    endtask

    task automatic fetchWord(input evrBusPkg::apbAddr_t addr, output evrBusPkg::apbData_t data);
        busTransfer(1'b0, addr, '0, 1'b0, data);
    endtask

    // config write also drops any pending pulse
    task automatic setChannelReg(input evrBusPkg::regIndex_t idx, input evrBusPkg::apbData_t value);
        int chan;
        storeWord(regAddress(idx), value, 1'b0);
        chan = idx >> 1;
        if (idx == evrBusPkg::RegPolarity) begin
            for (int c = 0; c < NumChannels; c++) begin
                shadowCfg[c].polarity = value[c];
                fireCycle[c] = -1;
            end
        end else if (idx[0]) begin
            shadowCfg[chan].width = value;
            fireCycle[chan] = -1;
        end else begin
            shadowCfg[chan].delay = value;
            fireCycle[chan] = -1;
        end
    endtask

    task automatic mapEntry(input evrEventPkg::eventCode_t code, input evrEventPkg::mapWord_t word);
        storeWord(ramAddress(code), 32'(word), 1'b0);
        ramShadow[code] = word;
    endtask

    //////////////////////////////////////////////////
    // event stream
    //////////////////////////////////////////////////

    // one real code followed by a null
    task automatic sendEvent(input evrEventPkg::eventCode_t code);
        @(posedge mgt_rec_clk);
        #DriveDelay;
        eventByte    = code;
        eventByteIsK = 1'b0;
        for (int c = 0; c < NumChannels; c++) begin
            // busy channels ignore the hit
            if (ramShadow[code][c] && (fireCycle[c] < 0 || shadowCfg[c].width == '0 ||
                cycleCount > fireCycle[c] + int'(shadowCfg[c].delay) +
                int'(shadowCfg[c].width))) begin
                fireCycle[c] = cycleCount;
            end
        end
        @(posedge mgt_rec_clk);
        #DriveDelay;
        eventByte = evrEventPkg::NullCode;
    endtask

    // nulls with the odd comma K mixed in
    task automatic idleFor(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge mgt_rec_clk);
            #DriveDelay;
            eventByteIsK = ($urandom_range(0, 3) == 0);
            eventByte    = eventByteIsK ? CommaK : evrEventPkg::NullCode;
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        evrBusPkg::apbData_t     rdata;
        evrBusPkg::apbData_t     polarity;
        evrEventPkg::eventCode_t codes [NumPulses];
        evrEventPkg::eventCode_t ramIdx [8];
        int                      activeSeen;

        void'($urandom(RandomSeed));
        apbReq       = '0;
        eventByte    = evrEventPkg::NullCode;
        eventByteIsK = 1'b0;
        for (int c = 0; c < NumChannels; c++) begin
            shadowCfg[c] = '0;
            fireCycle[c] = -1;
        end
        @(posedge bus_reset_n);

        // register bank
        for (int c = 0; c < NumChannels; c++) begin
            setChannelReg(8'(2 * c), $urandom_range(0, 20));
            setChannelReg(8'(2 * c + 1), $urandom_range(0, 10));
        end
        polarity = $urandom_range(0, 15);
        setChannelReg(evrBusPkg::RegPolarity, polarity);
        for (int c = 0; c < NumChannels; c++) begin
            fetchWord(regAddress(8'(2 * c)), rdata);
            compareWord("delay register", rdata, shadowCfg[c].delay);
            fetchWord(regAddress(8'(2 * c + 1)), rdata);
            compareWord("width register", rdata, shadowCfg[c].width);
        end
        fetchWord(regAddress(evrBusPkg::RegPolarity), rdata);
        compareWord("polarity register", rdata, polarity);
        fetchWord(regAddress(evrBusPkg::RegId), rdata);
        compareWord("ID register", rdata, evrBusPkg::EvrId);
        // read-only and unused indices
        storeWord(regAddress(evrBusPkg::RegId), 32'hFFFF_FFFF, 1'b1);
        fetchWord(regAddress(evrBusPkg::RegId), rdata);
        compareWord("ID after write", rdata, evrBusPkg::EvrId);
        storeWord(regAddress(8'd40), $urandom, 1'b1);
        busTransfer(1'b0, regAddress(8'd41), '0, 1'b1, rdata);

        // mapping RAM in the upper half of the code space
        for (int i = 0; i < 8; i++) begin
            ramIdx[i] = 8'(128 + 16 * i + $urandom_range(0, 15));
            mapEntry(ramIdx[i], 16'($urandom));
        end
        for (int i = 0; i < 8; i++) begin
            fetchWord(ramAddress(ramIdx[i]), rdata);
            compareWord("mapping word", rdata, 32'(ramShadow[ramIdx[i]]));
        end

        // trigger pulses from random codes on random channel masks
        for (int i = 0; i < NumPulses; i++) begin
            codes[i] = 8'(1 + 12 * i + $urandom_range(0, 11));
            mapEntry(codes[i], {1'b0, 11'($urandom), 4'($urandom_range(1, 15))});
        end
        mapEntry(BusyCode, 16'h0000);
        mapEntry(IrqCode, 16'h8000);
        mapEntry(ReconfCode, 16'h0001);
        idleFor(4);
        for (int i = 0; i < NumPulses; i++) begin
            sendEvent(codes[i]);
            idleFor(Gap);
        end

        // map read held off by a busy event stream
        fork
            begin
                for (int i = 0; i < BusyCycles; i++) begin
                    @(posedge mgt_rec_clk);
                    #DriveDelay;
                    eventByte    = BusyCode;
                    eventByteIsK = 1'b0;
                    @(negedge mgt_rec_clk);
                    assert (!apbRsp.pready)
                    else begin
                        valueErrors++;
                        $display("FAIL %0t: pready high while events own the RAM", $time);
                    end
                end
                @(posedge mgt_rec_clk);
                #DriveDelay;
                eventByte = evrEventPkg::NullCode;
            end
            fetchWord(ramAddress(ramIdx[0]), rdata);
        join
        compareWord("mapping word after back-pressure", rdata, 32'(ramShadow[ramIdx[0]]));

        // interrupt from mapping bit 15
        storeWord(regAddress(evrBusPkg::RegStatus), 32'd1, 1'b0);
        compareWord("intrEvent before event", 32'(intrEvent), 32'd0);
        sendEvent(IrqCode);
        @(posedge mgt_rec_clk);
        @(negedge mgt_rec_clk);
        compareWord("intrEvent after event", 32'(intrEvent), 32'd1);
        idleFor(5);
        fetchWord(regAddress(evrBusPkg::RegStatus), rdata);
        compareWord("status flag set", rdata, 32'd1);
        // writing 0 keeps it
        storeWord(regAddress(evrBusPkg::RegStatus), 32'd0, 1'b0);
        compareWord("intrEvent after writing 0", 32'(intrEvent), 32'd1);
        storeWord(regAddress(evrBusPkg::RegStatus), 32'd1, 1'b0);
        compareWord("intrEvent after clear", 32'(intrEvent), 32'd0);
        fetchWord(regAddress(evrBusPkg::RegStatus), rdata);
        compareWord("status flag cleared", rdata, 32'd0);

        // delay write while a pulse is pending
        setChannelReg(8'd0, 32'd30);
        setChannelReg(8'd1, 32'd5);
        sendEvent(ReconfCode);
        idleFor(5);
        setChannelReg(8'd0, 32'd3);
        activeSeen = 0;
        repeat (50) begin
            @(negedge mgt_rec_clk);
            if (triggers[0] !== shadowCfg[0].polarity) begin
                activeSeen++;
            end
        end
        compareWord("active cycles after reconfiguration", activeSeen, 0);
        // new setting takes effect on the next event
        sendEvent(ReconfCode);
        idleFor(15);

        idleFor(2);
        assertErrors = eventReceiverTop_i.evrApbRegs_i.evrApbAsserts_i.failCount;
        $display("Errors: %0d value, %0d protocol, %0d assertion", valueErrors,
                 protocolErrors, assertErrors);
        if (valueErrors + protocolErrors + assertErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(2 * TestCycles * ClkPeriod);
        $display("Watchdog expired at cycle %0d, the tests did not finish", cycleCount);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* list.f */
evrEventPkg.sv
evrBusPkg.sv
evrApbRegs.sv
mapRamArbiter.sv
triggerChannel.sv
eventReceiverTop.sv
evrClockGen.sv
evrApb_asserts.sv
eventReceiverTb.sv

/* Bender.yml */
package:
  name: eventReceiver

sources:
  # packages first, the bus package uses the event package
  - evrEventPkg.sv
  - evrBusPkg.sv
  - evrApbRegs.sv
  - mapRamArbiter.sv
  - triggerChannel.sv
  - eventReceiverTop.sv
  - target: test
    files:
      - evrClockGen.sv
      - evrApb_asserts.sv
      - eventReceiverTb.sv
